// ==== verilog/dcache_pkg.sv ====
package dcache_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  strb_t;   // one bit per byte lane

    // processor load/store request
    typedef struct packed {
        logic  wr;      // 1 = store
        addr_t addr;
        word_t wdata;
        strb_t strb;    // ignored on loads
    } cpu_req_t;

    // write channel beat, always one full word
    typedef struct packed {
        word_t data;
        logic  last;
    } mem_w_t;

    // read channel beat
    typedef struct packed {
        word_t data;
        logic  last;
    } mem_r_t;

    // miss controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,  // dirty victim out on the write channel
        REFILL,
        RESPOND
    } ctrl_state_t;

endpackage

// ==== verilog/tag_state_array.sv ====
`timescale 1ns/1ps

module tag_state_array #(
    parameter int LEN_LINE = 4,
    parameter int LEN_INDEX = 4,
    localparam int TAG_W = 32 - LEN_LINE - LEN_INDEX
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [LEN_INDEX-1:0] lookup_index,
    input  logic [TAG_W-1:0]     lookup_tag,
    output logic                 hit,
    output logic                 hit_way,
    output logic                 victim_way,
    output logic                 victim_dirty,
    output logic [TAG_W-1:0]     victim_tag,
    input  logic                 upd_en,
    input  logic [LEN_INDEX-1:0] upd_index,
    input  logic                 upd_way,
    input  logic [TAG_W-1:0]     upd_tag,
    input  logic                 upd_fill,
    input  logic                 upd_dirty
);
    localparam int SETS = 1 << LEN_INDEX;

    logic [TAG_W-1:0]     tag_q [2][SETS];
    logic [1:0]           valid_q [SETS];   // [set][way]
    logic [1:0]           dirty_q [SETS];
    logic [SETS-1:0]      lru_q;            // names the next victim
    logic [LEN_INDEX-1:0] lkp_index_q;
    logic [TAG_W-1:0]     lkp_tag_q;
    logic [1:0]           match;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
            lru_q       <= '0;
            lkp_index_q <= '0;
        end else begin
            lkp_index_q <= lookup_index;
            if (upd_en) begin
                lru_q[upd_index] <= ~upd_way;
                if (upd_fill) begin
                    valid_q[upd_index][upd_way] <= 1'b1;
                    dirty_q[upd_index][upd_way] <= upd_dirty;
                end else if (upd_dirty) begin
                    dirty_q[upd_index][upd_way] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        lkp_tag_q <= lookup_tag;
        if (upd_en && upd_fill) begin
            tag_q[upd_way][upd_index] <= upd_tag;
        end
    end

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            match[w] = valid_q[lkp_index_q][w] && (tag_q[w][lkp_index_q] == lkp_tag_q);
        end
    end

    assign hit          = |match;
    assign hit_way      = match[1];
    assign victim_way   = lru_q[lkp_index_q];
    assign victim_dirty = valid_q[lkp_index_q][victim_way] && dirty_q[lkp_index_q][victim_way];
    assign victim_tag   = tag_q[victim_way][lkp_index_q];

    // a fill only goes to the victim of a miss, so a line never sits in both ways
    a_one_way: assert property (@(posedge clk) disable iff (rst) !(match[0] && match[1]));

endmodule

// ==== verilog/data_array.sv ====
`timescale 1ns/1ps

module data_array #(
    parameter int LEN_LINE = 4,
    parameter int LEN_INDEX = 4,
    localparam int WORD_W = LEN_LINE - 2
) (
    input  logic                   clk,
    input  logic [LEN_INDEX-1:0]   rd_index,
    input  logic [WORD_W-1:0]      rd_word,
    input  logic                   rd_way,
    output dcache_pkg::word_t      rd_data,
    input  logic                   wr_en,
    input  logic [LEN_INDEX-1:0]   wr_index,
    input  logic [WORD_W-1:0]      wr_word,
    input  logic                   wr_way,
    input  dcache_pkg::word_t      wr_data,
    input  dcache_pkg::strb_t      wr_strb
);
    import dcache_pkg::*;

    localparam int DEPTH = 1 << (LEN_INDEX + WORD_W);

    word_t mem [2][DEPTH];
    word_t rd_q [2];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_way][{wr_index, wr_word}][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
        // both banks read every cycle
        rd_q[0] <= mem[0][{rd_index, rd_word}];
        rd_q[1] <= mem[1][{rd_index, rd_word}];
    end

    // way picked after the registered read, so the hit way can come late
    assign rd_data = rd_q[rd_way];

endmodule

// ==== verilog/miss_controller.sv ====
`timescale 1ns/1ps

module miss_controller #(
    parameter int LEN_LINE = 4,
    parameter int LEN_INDEX = 4,
    localparam int TAG_W = 32 - LEN_LINE - LEN_INDEX,
    localparam int WORD_W = LEN_LINE - 2
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  dcache_pkg::cpu_req_t   req,
    output logic                   resp_valid,
    output dcache_pkg::word_t      resp_rdata,
    output logic                   ar_valid,
    input  logic                   ar_ready,
    output dcache_pkg::addr_t      ar_addr,
    input  logic                   r_valid,
    output logic                   r_ready,
    input  dcache_pkg::mem_r_t     r_beat,
    output logic                   aw_valid,
    input  logic                   aw_ready,
    output dcache_pkg::addr_t      aw_addr,
    output logic                   w_valid,
    input  logic                   w_ready,
    output dcache_pkg::mem_w_t     w_beat,
    input  logic                   b_valid,
    output logic [LEN_INDEX-1:0]   lookup_index,
    output logic [TAG_W-1:0]       lookup_tag,
    input  logic                   hit,
    input  logic                   hit_way,
    input  logic                   victim_way,
    input  logic                   victim_dirty,
    input  logic [TAG_W-1:0]       victim_tag,
    output logic                   upd_en,
    output logic [LEN_INDEX-1:0]   upd_index,
    output logic                   upd_way,
    output logic [TAG_W-1:0]       upd_tag,
    output logic                   upd_fill,
    output logic                   upd_dirty,
    output logic [LEN_INDEX-1:0]   rd_index,
    output logic [WORD_W-1:0]      rd_word,
    output logic                   rd_way,
    input  dcache_pkg::word_t      rd_data,
    output logic                   wr_en,
    output logic [LEN_INDEX-1:0]   wr_index,
    output logic [WORD_W-1:0]      wr_word,
    output logic                   wr_way,
    output dcache_pkg::word_t      wr_data,
    output dcache_pkg::strb_t      wr_strb
);
    import dcache_pkg::*;

    ctrl_state_t          state;
    cpu_req_t             req_q;
    logic                 victim_way_q;
    word_t                resp_q;
    logic [WORD_W-1:0]    beat_cnt_q;   // write-back or refill word
    logic [WORD_W-1:0]    beat_nxt;
    logic                 wb_primed_q;  // first victim word is on rd_data
    logic                 wb_sent_q;
    logic                 w_fire, r_fire;
    logic [LEN_INDEX-1:0] req_index;
    logic [TAG_W-1:0]     req_tag;
    logic [WORD_W-1:0]    req_word;
    word_t                hit_word, fill_data;

    function automatic word_t merge_bytes(word_t old_w, word_t new_w, strb_t strb);
        word_t res;
        int    b;
        res = old_w;
        for (b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    assign req_index = req_q.addr[LEN_LINE +: LEN_INDEX];
    assign req_tag   = req_q.addr[31 -: TAG_W];
    assign req_word  = req_q.addr[2 +: WORD_W];

    assign req_ready = (state == IDLE);
    assign w_fire    = w_valid && w_ready;
    assign r_fire    = r_valid && r_ready;
    assign beat_nxt  = w_fire ? beat_cnt_q + WORD_W'(1) : beat_cnt_q;

    // incoming request addresses both arrays while idle
    assign lookup_index = (state == IDLE) ? req.addr[LEN_LINE +: LEN_INDEX] : req_index;
    assign lookup_tag   = (state == IDLE) ? req.addr[31 -: TAG_W] : req_tag;
    assign rd_index     = lookup_index;
    assign rd_word      = (state == IDLE) ? req.addr[2 +: WORD_W] :
                          (state == WRITEBACK) ? beat_nxt : req_word;
    assign rd_way       = (state == LOOKUP) ? hit_way : victim_way_q;

    assign hit_word  = req_q.wr ? merge_bytes(rd_data, req_q.wdata, req_q.strb) : rd_data;
    assign fill_data = (req_q.wr && beat_cnt_q == req_word) ?
                       merge_bytes(r_beat.data, req_q.wdata, req_q.strb) : r_beat.data;

    assign resp_valid = (state == LOOKUP && hit) || (state == RESPOND);
    assign resp_rdata = (state == RESPOND) ? resp_q : hit_word;

    assign wr_en    = (state == LOOKUP && hit && req_q.wr) || (state == REFILL && r_fire);
    assign wr_index = req_index;
    assign wr_word  = (state == REFILL) ? beat_cnt_q : req_word;
    assign wr_way   = (state == REFILL) ? victim_way_q : hit_way;
    assign wr_data  = (state == REFILL) ? fill_data : req_q.wdata;
    assign wr_strb  = (state == REFILL) ? 4'hf : req_q.strb;

    // lru and dirty on a hit, tag and valid on the last refill beat
    assign upd_en    = (state == LOOKUP && hit) || (state == REFILL && r_fire && r_beat.last);
    assign upd_index = req_index;
    assign upd_way   = (state == LOOKUP) ? hit_way : victim_way_q;
    assign upd_tag   = req_tag;
    assign upd_fill  = (state == REFILL);
    assign upd_dirty = req_q.wr;

    assign w_valid     = (state == WRITEBACK) && wb_primed_q && !wb_sent_q;
    assign w_beat.data = rd_data;   // re-read each cycle, so stable while stalled
    assign w_beat.last = &beat_cnt_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            ar_valid    <= 1'b0;
            aw_valid    <= 1'b0;
            r_ready     <= 1'b0;
            beat_cnt_q  <= '0;
            wb_primed_q <= 1'b0;
            wb_sent_q   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_valid) state <= LOOKUP;
                end
                LOOKUP: begin
                    if (hit) begin
                        state <= IDLE;
                    end else if (victim_dirty) begin
                        aw_valid <= 1'b1;
                        state    <= WRITEBACK;
                    end else begin
                        ar_valid <= 1'b1;
                        state    <= REFILL;
                    end
                    beat_cnt_q  <= '0;
                    wb_primed_q <= 1'b0;
                    wb_sent_q   <= 1'b0;
                end
                WRITEBACK: begin
                    if (aw_valid && aw_ready) aw_valid <= 1'b0;
                    if (!aw_valid) wb_primed_q <= 1'b1;   // data after the address
                    if (w_fire) begin
                        beat_cnt_q <= beat_nxt;
                        if (w_beat.last) wb_sent_q <= 1'b1;
                    end
                    if (wb_sent_q && b_valid) begin
                        ar_valid   <= 1'b1;
                        beat_cnt_q <= '0;
                        state      <= REFILL;
                    end
                end
                REFILL: begin
                    if (ar_valid) begin
                        if (ar_ready) begin
                            ar_valid <= 1'b0;
                            r_ready  <= 1'b1;
                        end
                    end else if (r_fire) begin
                        beat_cnt_q <= beat_cnt_q + WORD_W'(1);
                        if (r_beat.last) r_ready <= 1'b0;
                    end else if (!r_ready) begin
                        state <= RESPOND;   // one spare cycle after the last beat
                    end
                end
                RESPOND: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) req_q <= req;
        if (state == LOOKUP) begin
            victim_way_q <= victim_way;
            aw_addr      <= {victim_tag, req_index, {LEN_LINE{1'b0}}};
            ar_addr      <= {req_tag, req_index, {LEN_LINE{1'b0}}};
        end
        if (r_fire && beat_cnt_q == req_word) resp_q <= fill_data;
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr));

    a_ar_aw_excl: assert property (@(posedge clk) disable iff (rst)
        !(ar_valid && aw_valid));

    a_resp_pulse: assert property (@(posedge clk) disable iff (rst)
        resp_valid |=> !resp_valid);

endmodule

// ==== verilog/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top #(
    parameter int LEN_LINE = 4,
    parameter int LEN_INDEX = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  dcache_pkg::cpu_req_t   req,
    output logic                   resp_valid,
    output dcache_pkg::word_t      resp_rdata,
    output logic                   ar_valid,
    input  logic                   ar_ready,
    output dcache_pkg::addr_t      ar_addr,
    input  logic                   r_valid,
    output logic                   r_ready,
    input  dcache_pkg::mem_r_t     r_beat,
    output logic                   aw_valid,
    input  logic                   aw_ready,
    output dcache_pkg::addr_t      aw_addr,
    output logic                   w_valid,
    input  logic                   w_ready,
    output dcache_pkg::mem_w_t     w_beat,
    input  logic                   b_valid
);
    import dcache_pkg::*;

    localparam int TAG_W = 32 - LEN_LINE - LEN_INDEX;
    localparam int WORD_W = LEN_LINE - 2;

    logic [LEN_INDEX-1:0] lookup_index, upd_index, rd_index, wr_index;
    logic [TAG_W-1:0]     lookup_tag, victim_tag, upd_tag;
    logic [WORD_W-1:0]    rd_word, wr_word;
    logic                 hit, hit_way, victim_way, victim_dirty;
    logic                 upd_en, upd_way, upd_fill, upd_dirty;
    logic                 rd_way, wr_en, wr_way;
    word_t                rd_data, wr_data;
    strb_t                wr_strb;

    tag_state_array #(.LEN_LINE(LEN_LINE), .LEN_INDEX(LEN_INDEX)) u_tags (
        .clk(clk), .rst(rst),
        .lookup_index(lookup_index), .lookup_tag(lookup_tag),
        .hit(hit), .hit_way(hit_way),
        .victim_way(victim_way), .victim_dirty(victim_dirty), .victim_tag(victim_tag),
        .upd_en(upd_en), .upd_index(upd_index), .upd_way(upd_way),
        .upd_tag(upd_tag), .upd_fill(upd_fill), .upd_dirty(upd_dirty)
    );

    data_array #(.LEN_LINE(LEN_LINE), .LEN_INDEX(LEN_INDEX)) u_data (
        .clk(clk),
        .rd_index(rd_index), .rd_word(rd_word), .rd_way(rd_way), .rd_data(rd_data),
        .wr_en(wr_en), .wr_index(wr_index), .wr_word(wr_word), .wr_way(wr_way),
        .wr_data(wr_data), .wr_strb(wr_strb)
    );

    miss_controller #(.LEN_LINE(LEN_LINE), .LEN_INDEX(LEN_INDEX)) u_ctrl (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .resp_valid(resp_valid), .resp_rdata(resp_rdata),
        .ar_valid(ar_valid), .ar_ready(ar_ready), .ar_addr(ar_addr),
        .r_valid(r_valid), .r_ready(r_ready), .r_beat(r_beat),
        .aw_valid(aw_valid), .aw_ready(aw_ready), .aw_addr(aw_addr),
        .w_valid(w_valid), .w_ready(w_ready), .w_beat(w_beat), .b_valid(b_valid),
        .lookup_index(lookup_index), .lookup_tag(lookup_tag),
        .hit(hit), .hit_way(hit_way),
        .victim_way(victim_way), .victim_dirty(victim_dirty), .victim_tag(victim_tag),
        .upd_en(upd_en), .upd_index(upd_index), .upd_way(upd_way),
        .upd_tag(upd_tag), .upd_fill(upd_fill), .upd_dirty(upd_dirty),
        .rd_index(rd_index), .rd_word(rd_word), .rd_way(rd_way), .rd_data(rd_data),
        .wr_en(wr_en), .wr_index(wr_index), .wr_word(wr_word), .wr_way(wr_way),
        .wr_data(wr_data), .wr_strb(wr_strb)
    );

endmodule

// ==== tb/mem_model.sv ====
`timescale 1ns/1ps

module mem_model #(
    parameter int LINE_WORDS = 4,
    parameter dcache_pkg::word_t FILL_KEY = 32'h0
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                ar_valid,
    output logic                ar_ready = 1'b0,
    input  dcache_pkg::addr_t   ar_addr,
    output logic                r_valid = 1'b0,
    input  logic                r_ready,
    output dcache_pkg::mem_r_t  r_beat = '0,
    input  logic                aw_valid,
    output logic                aw_ready = 1'b0,
    input  dcache_pkg::addr_t   aw_addr,
    input  logic                w_valid,
    output logic                w_ready = 1'b0,
    input  dcache_pkg::mem_w_t  w_beat,
    output logic                b_valid = 1'b0
);
    import dcache_pkg::*;

    word_t       store [addr_t];   // keyed by word address
    logic [31:0] lcg_q;
    addr_t       rd_base, wr_base;
    int          rd_cnt, wr_cnt;
    logic        rd_busy, wr_busy, b_pend;

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic word_t read_word(addr_t waddr);
        if (store.exists(waddr)) begin
            return store[waddr];
        end
        return waddr ^ FILL_KEY;   // never written
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            lcg_q    <= 32'd30970;
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            b_valid  <= 1'b0;
            rd_busy  <= 1'b0;
            wr_busy  <= 1'b0;
            b_pend   <= 1'b0;
        end else begin
            lcg_q <= lcg_next(lcg_q);
            if (ar_valid && ar_ready) begin
                ar_ready <= 1'b0;
                rd_busy  <= 1'b1;
                rd_base  <= ar_addr >> 2;
                rd_cnt   <= 0;
            end else begin
                ar_ready <= !rd_busy && (lcg_q[17:16] != 2'b00);
            end
            if (r_valid && r_ready) begin
                r_valid <= 1'b0;
                rd_cnt  <= rd_cnt + 1;
                if (r_beat.last) rd_busy <= 1'b0;
            end else if (rd_busy && !r_valid && (lcg_q[19:18] != 2'b00)) begin
                r_valid     <= 1'b1;
                r_beat.data <= read_word(rd_base + addr_t'(rd_cnt));
                r_beat.last <= (rd_cnt == LINE_WORDS - 1);
            end
            if (aw_valid && aw_ready) begin
                aw_ready <= 1'b0;
                wr_busy  <= 1'b1;
                wr_base  <= aw_addr >> 2;
                wr_cnt   <= 0;
            end else begin
                aw_ready <= !wr_busy && (lcg_q[21:20] != 2'b00);
            end
            if (w_valid && w_ready) begin
                store[wr_base + addr_t'(wr_cnt)] = w_beat.data;
                wr_cnt  <= wr_cnt + 1;
                w_ready <= 1'b0;
                if (w_beat.last) b_pend <= 1'b1;
            end else begin
                w_ready <= wr_busy && !b_pend && (lcg_q[23:22] != 2'b00);
            end
            // response at least one cycle after the last beat
            if (b_valid) begin
                b_valid <= 1'b0;
            end else if (b_pend && (lcg_q[25:24] != 2'b00)) begin
                b_valid <= 1'b1;
                b_pend  <= 1'b0;
                wr_busy <= 1'b0;
            end
        end
    end

endmodule

// ==== tb/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int LEN_LINE    = 4;
    localparam int LEN_INDEX   = 4;
    localparam int CLK_PERIOD  = 4;
    localparam int N_OPS       = 16;
    localparam int OP_BUDGET   = 300;   // worst case cycles per entry
    localparam word_t FILL_KEY = 32'h6b3c_91e5;

    typedef struct packed {
        logic  wr;
        addr_t addr;
        word_t data;
        strb_t strb;
        logic  exp_aw;
        addr_t aw_line;
        logic  exp_ar;
        addr_t ar_line;
    } op_t;

    logic     clk = 1'b0;
    logic     rst = 1'b1;
    logic     req_valid = 1'b0;
    cpu_req_t req = '0;
    logic     req_ready, resp_valid;
    word_t    resp_rdata;
    logic     ar_valid, ar_ready, r_valid, r_ready;
    logic     aw_valid, aw_ready, w_valid, w_ready, b_valid;
    addr_t    ar_addr, aw_addr;
    mem_r_t   r_beat;
    mem_w_t   w_beat;

    op_t   ops [N_OPS];
    word_t shadow [addr_t];   // word address to expected contents
    int    cycle = 0;
    int    ar_count = 0;
    int    aw_count = 0;
    int    ar_cycle, aw_cycle;
    addr_t ar_seen, aw_seen;

    always #(CLK_PERIOD / 2) clk = ~clk;

    dcache_top #(.LEN_LINE(LEN_LINE), .LEN_INDEX(LEN_INDEX)) uut (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .resp_valid(resp_valid), .resp_rdata(resp_rdata),
        .ar_valid(ar_valid), .ar_ready(ar_ready), .ar_addr(ar_addr),
        .r_valid(r_valid), .r_ready(r_ready), .r_beat(r_beat),
        .aw_valid(aw_valid), .aw_ready(aw_ready), .aw_addr(aw_addr),
        .w_valid(w_valid), .w_ready(w_ready), .w_beat(w_beat), .b_valid(b_valid)
    );

    mem_model #(.LINE_WORDS(1 << (LEN_LINE - 2)), .FILL_KEY(FILL_KEY)) u_mem (
        .clk(clk), .rst(rst),
        .ar_valid(ar_valid), .ar_ready(ar_ready), .ar_addr(ar_addr),
        .r_valid(r_valid), .r_ready(r_ready), .r_beat(r_beat),
        .aw_valid(aw_valid), .aw_ready(aw_ready), .aw_addr(aw_addr),
        .w_valid(w_valid), .w_ready(w_ready), .w_beat(w_beat), .b_valid(b_valid)
    );

    // bus monitor
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (ar_valid && ar_ready) begin
            ar_count <= ar_count + 1;
            ar_seen  <= ar_addr;
            ar_cycle <= cycle;
        end
        if (aw_valid && aw_ready) begin
            aw_count <= aw_count + 1;
            aw_seen  <= aw_addr;
            aw_cycle <= cycle;
        end
    end

    function automatic word_t shadow_word(addr_t byte_addr);
        addr_t waddr;
        waddr = byte_addr >> 2;
        if (shadow.exists(waddr)) begin
            return shadow[waddr];
        end
        return waddr ^ FILL_KEY;
    endfunction

    function automatic word_t apply_strobe(word_t old_w, word_t new_w, strb_t strb);
        word_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    task automatic abort_run(string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_word(word_t got, word_t exp, string what);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH at %0d ns: %s got %08h, expected %08h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_addr(addr_t got, addr_t exp, string what);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH at %0d ns: %s got %08h, expected %08h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH at %0d ns: %s got %0b, expected %0b",
                                $time, what, got, exp));
        end
    endtask

    task automatic run_op(int idx, op_t op);
        word_t expected;
        int    ar0, aw0, t_acc;
        string tag;
        tag = $sformatf("op %0d", idx);
        ar0 = ar_count;
        aw0 = aw_count;
        expected = shadow_word(op.addr);
        if (op.wr) begin
            expected = apply_strobe(expected, op.data, op.strb);
            shadow[op.addr >> 2] = expected;
        end
        req_valid <= 1'b1;
        req <= '{wr: op.wr, addr: op.addr, wdata: op.data, strb: op.strb};
        do @(posedge clk); while (!req_ready);
        t_acc = cycle;
        req_valid <= 1'b0;
        do @(posedge clk); while (!resp_valid);
        check_word(resp_rdata, expected, {tag, " response data"});
        check_flag(aw_count != aw0, op.exp_aw, {tag, " AW burst"});
        check_flag(ar_count != ar0, op.exp_ar, {tag, " AR burst"});
        check_flag((aw_count - aw0 > 1) || (ar_count - ar0 > 1), 1'b0, {tag, " extra burst"});
        if (op.exp_aw) check_addr(aw_seen, op.aw_line, {tag, " AW line address"});
        if (op.exp_ar) check_addr(ar_seen, op.ar_line, {tag, " AR line address"});
        if (op.exp_aw && op.exp_ar) begin
            check_flag(aw_cycle < ar_cycle, 1'b1, {tag, " AW before AR"});
        end
        if (!op.exp_aw && !op.exp_ar) begin
            check_flag(cycle - t_acc == 1, 1'b1, {tag, " hit latency"});   // one cycle
        end
    endtask

    initial begin
        // wr, addr, data, strb, exp_aw, aw_line, exp_ar, ar_line
        ops[0]  = '{1'b0, 32'h0000_1034, 32'h0, 4'h0, 1'b0, 32'h0, 1'b1, 32'h0000_1030};
        ops[1]  = '{1'b0, 32'h0000_1038, 32'h0, 4'h0, 1'b0, 32'h0, 1'b0, 32'h0};
        ops[2]  = '{1'b1, 32'h0000_1034, 32'hdead_beef, 4'b0101, 1'b0, 32'h0, 1'b0, 32'h0};
        ops[3]  = '{1'b0, 32'h0000_1034, 32'h0, 4'h0, 1'b0, 32'h0, 1'b0, 32'h0};
        ops[4]  = '{1'b1, 32'h0000_203c, 32'h1122_3344, 4'b1100, 1'b0, 32'h0,
                    1'b1, 32'h0000_2030};
        ops[5]  = '{1'b0, 32'h0000_203c, 32'h0, 4'h0, 1'b0, 32'h0, 1'b0, 32'h0};
        // third and fourth tag in set 3 push out the dirty lines
        ops[6]  = '{1'b0, 32'h0000_3030, 32'h0, 4'h0, 1'b1, 32'h0000_1030,
                    1'b1, 32'h0000_3030};
        ops[7]  = '{1'b0, 32'h0000_4034, 32'h0, 4'h0, 1'b1, 32'h0000_2030,
                    1'b1, 32'h0000_4030};
        ops[8]  = '{1'b0, 32'h0000_1034, 32'h0, 4'h0, 1'b0, 32'h0, 1'b1, 32'h0000_1030};
        ops[9]  = '{1'b0, 32'h0000_203c, 32'h0, 4'h0, 1'b0, 32'h0, 1'b1, 32'h0000_2030};
        ops[10] = '{1'b0, 32'h0000_1030, 32'h0, 4'h0, 1'b0, 32'h0, 1'b0, 32'h0};
        ops[11] = '{1'b0, 32'h0000_3038, 32'h0, 4'h0, 1'b0, 32'h0, 1'b1, 32'h0000_3030};
        ops[12] = '{1'b1, 32'h0000_5040, 32'hcafe_f00d, 4'hf, 1'b0, 32'h0,
                    1'b1, 32'h0000_5040};
        ops[13] = '{1'b0, 32'h0000_5040, 32'h0, 4'h0, 1'b0, 32'h0, 1'b0, 32'h0};
        ops[14] = '{1'b1, 32'h0000_5040, 32'h0000_ab00, 4'b0010, 1'b0, 32'h0, 1'b0, 32'h0};
        ops[15] = '{1'b0, 32'h0000_5044, 32'h0, 4'h0, 1'b0, 32'h0, 1'b0, 32'h0};

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_flag(req_ready, 1'b1, "req_ready after reset");
        check_flag(resp_valid, 1'b0, "resp_valid after reset");
        check_flag(ar_valid, 1'b0, "ar_valid after reset");
        check_flag(aw_valid, 1'b0, "aw_valid after reset");
        check_flag(w_valid, 1'b0, "w_valid after reset");
        check_flag(r_ready, 1'b0, "r_ready after reset");

        for (int i = 0; i < N_OPS; i++) begin
            run_op(i, ops[i]);
        end
        $display("TB PASSED");
        $finish;
    end

    // watchdog
    initial begin
        #((12 + N_OPS * OP_BUDGET) * CLK_PERIOD);
        abort_run("timeout: the operation table did not complete within its cycle budget");
    end

endmodule

// ==== filelist.f ====
verilog/dcache_pkg.sv
verilog/tag_state_array.sv
verilog/data_array.sv
verilog/miss_controller.sv
verilog/dcache_top.sv
tb/mem_model.sv
tb/dcache_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := dcache_tb
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
